// ==== sim/pio_sm_stimulus.txt ====
# Letter then hex fields: W addr instr, C shiftdir thresh, T word, G cycles,
# P pc, E word (pop RX and compare), M (RX empty). Several records may share a line.
# SET, MOV and PUSH
C 1 00
W 00 E035 W 01 A0C1 W 02 8020 W 03 A043 W 04 A0C2 W 05 8020 W 06 0006
G 0A P 06 E 15 E 0 M
# X-- loop, then X_NE_Y and Y_ZERO branches
W 06 E023 W 07 E047 W 08 0047 W 09 A0C2 W 0A 8020 W 0B A0C1 W 0C 8020
W 0D 00B0 W 0E E041 W 0F 0011 W 10 E040 W 11 0074 W 12 E049 W 13 0015
W 14 E05A W 15 A0C2 W 16 8020 W 17 0017
G 1E P 17 E 7 E FFFFFFFF E 1A M
# PULL and OUT 8 shifting right, then left, then OUT 0 moves a full word
C 1 00 T 12345678
W 17 80A0 W 18 6028 W 19 A0C1 W 1A 8020 W 1B 001B
G 08 P 1B E 78 M
C 0 00 T 12ABCDEF
W 1B 80A0 W 1C 6028 W 1D A0C1 W 1E 8020 W 1F 6040 W 00 A0C2 W 01 8020 W 02 0002
G 0C P 02 E 12 E ABCDEF00 M
# OSR_NOT_EMPTY loop and PULL if-empty with thresh 16
C 1 10 T AABBCCDD T 11223344
W 02 80A0 W 03 80E0 W 04 6028 W 05 00E4 W 06 80E0 W 07 6040 W 08 A0C1
W 09 8020 W 0A A0C2 W 0B 8020 W 0C 000C
G 14 P 0C E CC E 11223344 M
# Blocking PULL stalls on empty TX, non-blocking PULL takes X
W 0C 80A0 W 0D 6020 W 0E A0C1 W 0F 8020 W 10 E033 W 11 8080 W 12 A047
W 13 A0C2 W 14 8020 W 15 0015
G 0A P 0C
T 5A5A5A5A G 0F P 15 E 5A5A5A5A E 13 M
# RX full, the fifth blocking PUSH waits for host pops
W 15 E024 W 16 A0C1 W 17 8020 W 18 0056 W 19 0019
G 18 P 17 E 4 E 3 E 2 E 1
G 0A P 19 E 0 M

// ==== pio_sm.f ====
hdl/sm_pkg.sv
hdl/sync_fifo.sv
hdl/fetch_unit.sv
hdl/osr_unit.sv
hdl/sm_exec.sv
hdl/pio_sm.sv
sim/tb_pio_sm.sv

// ==== Makefile ====
TOP       ?= tb_pio_sm
VERILATOR ?= verilator
FLAGS     ?= --assert
FILELIST  ?= pio_sm.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== sim/tb_pio_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pio_sm;

    localparam int FIFO_DEPTH = 4;

    // One parsed line of the stimulus file
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
    } record_t;

    logic               clk;
    logic               rst;
    logic               imem_we;
    sm_pkg::pc_t        imem_addr;
    sm_pkg::instr_t     imem_wdata;
    logic               run;
    sm_pkg::sm_config_t cfg;
    logic               tx_push;
    sm_pkg::word_t      tx_wdata;
    logic               tx_full;
    logic               rx_pop;
    sm_pkg::word_t      rx_rdata;
    logic               rx_empty;
    sm_pkg::pc_t        pc;

    record_t recs[$];
    int      wd_cycles = 0;

    pio_sm #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk(clk), .rst(rst),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .run(run), .cfg(cfg),
        .tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_rdata(rx_rdata), .rx_empty(rx_empty),
        .pc(pc)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input sm_pkg::word_t exp,
                              input sm_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pc(input sm_pkg::pc_t exp, input sm_pkg::pc_t act);
        if (act !== exp) begin
            $display("ERR %0t pc expected %h actual %h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Idle machine, so every accepted push stays in the TX FIFO
    task automatic fill_tx_fifo();
        int i;
        for (i = 0; i < FIFO_DEPTH; i++) begin
            @(negedge clk);
            check_flag("tx_full", 1'b0, tx_full);
            @(posedge clk);
            tx_push  <= 1'b1;
            tx_wdata <= 32'(i);
            @(posedge clk);
            tx_push  <= 1'b0;
        end
        @(negedge clk);
        check_flag("tx_full", 1'b1, tx_full);
        // One push too many is dropped and the flag holds
        @(posedge clk);
        tx_push  <= 1'b1;
        tx_wdata <= 32'(FIFO_DEPTH);
        @(posedge clk);
        tx_push  <= 1'b0;
        @(negedge clk);
        check_flag("tx_full", 1'b1, tx_full);
    endtask

    // Lines starting with # are skipped
    task automatic read_records();
        int            fd;
        int            code;
        int            n;
        logic [7:0]    ch;
        logic [31:0]   val_a;
        logic [31:0]   val_b;
        logic [1023:0] rest;
        record_t       rec;
        fd = $fopen("sim/pio_sm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/pio_sm_stimulus.txt");
            abort_run();
        end else begin
            code = $fscanf(fd, " %c", ch);
            while (code == 1) begin
                val_a = '0;
                val_b = '0;
                if (ch == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    case (ch)
                        "W", "C":           n = $fscanf(fd, " %h %h", val_a, val_b) - 2;
                        "T", "G", "P", "E": n = $fscanf(fd, " %h", val_a) - 1;
                        "M":                n = 0;
                        default:            n = -1;
                    endcase
                    if (n != 0) begin
                        $display("Bad stimulus record starting with letter %c", ch);
                        abort_run();
                    end else begin
                        rec.kind = ch;
                        rec.a    = val_a;
                        rec.b    = val_b;
                        recs.push_back(rec);
                    end
                end
                code = $fscanf(fd, " %c", ch);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_record(input record_t rec);
        case (rec.kind)
            "W": begin
                @(posedge clk);
                imem_we    <= 1'b1;
                imem_addr  <= rec.a[4:0];
                imem_wdata <= rec.b[15:0];
                @(posedge clk);
                imem_we    <= 1'b0;
            end
            "C": begin
                @(posedge clk);
                cfg.out_shiftdir <= rec.a[0];
                cfg.pull_thresh  <= rec.b[4:0];
            end
            "T": begin
                @(posedge clk);
                tx_push  <= 1'b1;
                tx_wdata <= rec.a;
                @(posedge clk);
                tx_push  <= 1'b0;
            end
            "G": begin
                // One instruction per edge while run is high
                @(posedge clk);
                run <= 1'b1;
                repeat (rec.a) @(posedge clk);
                run <= 1'b0;
            end
            "P": begin
                @(negedge clk);
                check_pc(rec.a[4:0], pc);
            end
            "E": begin
                @(negedge clk);
                check_flag("rx_empty", 1'b0, rx_empty);
                check_word("rx_rdata", rec.a, rx_rdata);
                @(posedge clk);
                rx_pop <= 1'b1;
                @(posedge clk);
                rx_pop <= 1'b0;
            end
            "M": begin
                @(negedge clk);
                check_flag("rx_empty", 1'b1, rx_empty);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        int limit;
        clk        = 1'b0;
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        run        = 1'b0;
        cfg        = '0;
        tx_push    = 1'b0;
        tx_wdata   = '0;
        rx_pop     = 1'b0;
        read_records();
        // Run lengths plus slack per record
        limit = 100;
        foreach (recs[i]) begin
            limit += 20;
            if (recs[i].kind == "G") begin
                limit += int'(recs[i].a);
            end
        end
        wd_cycles = limit;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        fill_tx_fifo();
        // Fresh reset empties the TX FIFO before the programs run
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("tx_full", 1'b0, tx_full);
        foreach (recs[i]) begin
            apply_record(recs[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * 10);
        $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== hdl/pio_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_sm #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we,
    input  sm_pkg::pc_t        imem_addr,
    input  sm_pkg::instr_t     imem_wdata,
    input  logic               run,
    input  sm_pkg::sm_config_t cfg,
    input  logic               tx_push,
    input  sm_pkg::word_t      tx_wdata,
    output logic               tx_full,
    input  logic               rx_pop,
    output sm_pkg::word_t      rx_rdata,
    output logic               rx_empty,
    output sm_pkg::pc_t        pc
);

    sm_pkg::instr_t       instr;
    logic                 pc_advance;
    logic                 jump_taken;
    sm_pkg::pc_t          jump_target;
    sm_pkg::osr_ctrl_t    osr_ctrl;
    sm_pkg::word_t        osr_data;
    sm_pkg::word_t        shift_out;
    logic                 osr_empty;
    logic                 tx_pop;
    sm_pkg::word_t        tx_rdata;
    sm_pkg::fifo_status_t tx_status;
    logic                 rx_push;
    sm_pkg::word_t        rx_wdata;
    sm_pkg::fifo_status_t rx_status;

    assign tx_full  = tx_status.full;
    assign rx_empty = rx_status.empty;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .pc_advance(pc_advance), .jump_taken(jump_taken), .jump_target(jump_target),
        .instr(instr), .pc(pc)
    );

    sm_exec u_exec (
        .clk(clk), .rst(rst), .run(run), .instr(instr),
        .tx_status(tx_status), .tx_rdata(tx_rdata), .rx_status(rx_status),
        .osr_data(osr_data), .shift_out(shift_out), .osr_empty(osr_empty),
        .pc_advance(pc_advance), .jump_taken(jump_taken), .jump_target(jump_target),
        .osr_ctrl(osr_ctrl), .tx_pop(tx_pop), .rx_push(rx_push), .rx_wdata(rx_wdata)
    );

    osr_unit u_osr (
        .clk(clk), .rst(rst), .ctrl(osr_ctrl), .cfg(cfg),
        .osr_data(osr_data), .shift_out(shift_out), .osr_empty(osr_empty)
    );

    // Host to machine
    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk(clk), .rst(rst), .push(tx_push), .wdata(tx_wdata),
        .pop(tx_pop), .rdata(tx_rdata), .status(tx_status)
    );

    // Machine to host
    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk(clk), .rst(rst), .push(rx_push), .wdata(rx_wdata),
        .pop(rx_pop), .rdata(rx_rdata), .status(rx_status)
    );

endmodule

`default_nettype wire

// ==== hdl/sm_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_exec (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  sm_pkg::instr_t       instr,
    input  sm_pkg::fifo_status_t tx_status,
    input  sm_pkg::word_t        tx_rdata,
    input  sm_pkg::fifo_status_t rx_status,
    input  sm_pkg::word_t        osr_data,
    input  sm_pkg::word_t        shift_out,
    input  logic                 osr_empty,
    output logic                 pc_advance,
    output logic                 jump_taken,
    output sm_pkg::pc_t          jump_target,
    output sm_pkg::osr_ctrl_t    osr_ctrl,
    output logic                 tx_pop,
    output logic                 rx_push,
    output sm_pkg::word_t        rx_wdata
);

    sm_pkg::word_t        x;
    sm_pkg::word_t        y;
    sm_pkg::word_t        isr;
    sm_pkg::opcode_t      op;
    sm_pkg::mov_operand_t dest;
    sm_pkg::mov_operand_t mov_src;
    sm_pkg::word_t        src_value;
    logic                 cond_true;
    logic                 is_pull;
    logic                 is_push;
    logic                 pull_skip;
    logic                 stall;
    logic                 pull_exec;

    assign op      = instr.jmp.opcode;
    assign dest    = instr.opnd.dest;
    assign mov_src = sm_pkg::mov_operand_t'(instr.opnd.data[2:0]);

    // Conditions see X and Y before any decrement
    always_comb begin
        case (instr.jmp.cond)
            sm_pkg::ALWAYS:        cond_true = 1'b1;
            sm_pkg::X_ZERO:        cond_true = (x == '0);
            sm_pkg::X_NZ_DEC:      cond_true = (x != '0);
            sm_pkg::Y_ZERO:        cond_true = (y == '0);
            sm_pkg::Y_NZ_DEC:      cond_true = (y != '0);
            sm_pkg::X_NE_Y:        cond_true = (x != y);
            sm_pkg::OSR_NOT_EMPTY: cond_true = !osr_empty;
            default:               cond_true = 1'b0;  // PIN is reserved
        endcase
    end

    always_comb begin
        case (mov_src)
            sm_pkg::X:   src_value = x;
            sm_pkg::Y:   src_value = y;
            sm_pkg::ISR: src_value = isr;
            sm_pkg::OSR: src_value = osr_data;
            default:     src_value = '0;
        endcase
    end

    assign is_pull   = (op == sm_pkg::PUSH_PULL) && instr.fifo.pull;
    assign is_push   = (op == sm_pkg::PUSH_PULL) && !instr.fifo.pull;
    // If-empty pull with data still in the OSR does nothing
    assign pull_skip = is_pull && instr.fifo.if_empty && !osr_empty;

    assign stall = (is_pull && !pull_skip && instr.fifo.block && tx_status.empty)
                || (is_push && instr.fifo.block && rx_status.full);

    assign pull_exec   = run && is_pull && !pull_skip && !stall;
    assign pc_advance  = run && !stall;
    assign jump_taken  = run && (op == sm_pkg::JMP) && cond_true;
    assign jump_target = instr.jmp.target;

    assign tx_pop   = pull_exec && !tx_status.empty;
    assign rx_push  = run && is_push && !rx_status.full;
    assign rx_wdata = isr;

    always_comb begin
        osr_ctrl = '0;
        // OUT count of 0 moves a full word
        osr_ctrl.shift_count = (instr.opnd.data == 5'd0) ? 6'd32 : {1'b0, instr.opnd.data};
        if (pull_exec) begin
            // Non-blocking pull from an empty FIFO takes X
            osr_ctrl.load      = 1'b1;
            osr_ctrl.load_data = tx_status.empty ? x : tx_rdata;
        end else if (run && (op == sm_pkg::MOV) && (dest == sm_pkg::OSR)) begin
            osr_ctrl.load      = 1'b1;
            osr_ctrl.load_data = src_value;
        end
        osr_ctrl.shift_en = run && (op == sm_pkg::OUT);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x   <= '0;
            y   <= '0;
            isr <= '0;
        end else if (run && !stall) begin
            case (op)
                sm_pkg::JMP: begin
                    if (instr.jmp.cond == sm_pkg::X_NZ_DEC) begin
                        x <= x - 32'd1;
                    end
                    if (instr.jmp.cond == sm_pkg::Y_NZ_DEC) begin
                        y <= y - 32'd1;
                    end
                end
                sm_pkg::SET: begin
                    if (dest == sm_pkg::X) x <= {27'd0, instr.opnd.data};
                    if (dest == sm_pkg::Y) y <= {27'd0, instr.opnd.data};
                end
                sm_pkg::OUT: begin
                    if (dest == sm_pkg::X) x <= shift_out;
                    if (dest == sm_pkg::Y) y <= shift_out;
                end
                sm_pkg::MOV: begin
                    if (dest == sm_pkg::X)   x   <= src_value;
                    if (dest == sm_pkg::Y)   y   <= src_value;
                    if (dest == sm_pkg::ISR) isr <= src_value;
                end
                sm_pkg::PUSH_PULL: begin
                    // Cleared even when a full RX FIFO drops the push
                    if (!instr.fifo.pull) isr <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    a_one_fifo_strobe: assert property (@(posedge clk) disable iff (rst)
        !(tx_pop && rx_push))
        else $error("sm_exec: TX pop and RX push together");

endmodule

`default_nettype wire

// ==== hdl/osr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module osr_unit (
    input  logic               clk,
    input  logic               rst,
    input  sm_pkg::osr_ctrl_t  ctrl,
    input  sm_pkg::sm_config_t cfg,
    output sm_pkg::word_t      osr_data,
    output sm_pkg::word_t      shift_out,
    output logic               osr_empty
);

    sm_pkg::word_t  osr;
    sm_pkg::count_t shift_cnt;
    sm_pkg::count_t thresh;
    logic [6:0]     cnt_sum;

    assign osr_data = osr;

    assign thresh    = (cfg.pull_thresh == 5'd0) ? 6'd32 : {1'b0, cfg.pull_thresh};
    assign osr_empty = (shift_cnt >= thresh);

    // Shift amount is 1 to 32, shifts of 32 give all zeros
    always_comb begin
        if (cfg.out_shiftdir) begin
            shift_out = osr & ~({32{1'b1}} << ctrl.shift_count);
        end else begin
            // High bits, right-aligned
            shift_out = osr >> (6'd32 - ctrl.shift_count);
        end
    end

    assign cnt_sum = {1'b0, shift_cnt} + {1'b0, ctrl.shift_count};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            osr       <= '0;
            shift_cnt <= '0;
        end else if (ctrl.load) begin
            osr       <= ctrl.load_data;
            shift_cnt <= '0;
        end else if (ctrl.shift_en) begin
            if (cfg.out_shiftdir) begin
                osr <= osr >> ctrl.shift_count;
            end else begin
                osr <= osr << ctrl.shift_count;
            end
            // Saturate at a full word
            shift_cnt <= (cnt_sum > 7'd32) ? 6'd32 : cnt_sum[5:0];
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        shift_cnt <= 6'd32)
        else $error("osr_unit: shift counter above 32");

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           imem_we,
    input  sm_pkg::pc_t    imem_addr,
    input  sm_pkg::instr_t imem_wdata,
    input  logic           pc_advance,
    input  logic           jump_taken,
    input  sm_pkg::pc_t    jump_target,
    output sm_pkg::instr_t instr,
    output sm_pkg::pc_t    pc
);

    sm_pkg::instr_t imem [32];

    // Host write port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Decode happens in the same cycle as the read
    assign instr = imem[pc];

    // Rolls over at 32, no program wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (jump_taken) begin
            pc <= jump_target;
        end else if (pc_advance) begin
            pc <= pc + 5'd1;
        end
    end

    // A jump from the executor is never issued on a stalled cycle
    a_jump_advances: assert property (@(posedge clk) disable iff (rst)
        jump_taken |-> pc_advance)
        else $error("fetch_unit: jump while stalled");

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  sm_pkg::word_t        wdata,
    input  logic                 pop,
    output sm_pkg::word_t        rdata,
    output sm_pkg::fifo_status_t status
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    sm_pkg::word_t    mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Requests that cannot be served are dropped here
    assign do_push = push && !status.full;
    assign do_pop  = pop && !status.empty;

    assign status.full  = (count == CNT_W'(FIFO_DEPTH));
    assign status.empty = (count == '0);
    assign status.count = 3'(count);
    assign rdata        = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // A full buffer must never see its write pointer move
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        status.full && !do_pop |=> wr_ptr == $past(wr_ptr))
        else $error("sync_fifo: write while full");

    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        status.empty |=> rd_ptr == $past(rd_ptr))
        else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// ==== hdl/sm_pkg.sv ====
`default_nettype none

package sm_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  pc_t;
    // Shift count or threshold, 0 to 32
    typedef logic [5:0]  count_t;

    typedef enum logic [2:0] {
        JMP       = 3'd0,
        WAIT      = 3'd1,
        IN        = 3'd2,
        OUT       = 3'd3,
        PUSH_PULL = 3'd4,
        MOV       = 3'd5,
        IRQ       = 3'd6,
        SET       = 3'd7
    } opcode_t;

    typedef enum logic [2:0] {
        ALWAYS        = 3'd0,
        X_ZERO        = 3'd1,
        X_NZ_DEC      = 3'd2,
        Y_ZERO        = 3'd3,
        Y_NZ_DEC      = 3'd4,
        X_NE_Y        = 3'd5,
        PIN           = 3'd6,
        OSR_NOT_EMPTY = 3'd7
    } jmp_cond_t;

    // Shared by MOV/OUT/SET destinations and MOV sources
    typedef enum logic [2:0] {
        PINS = 3'd0,
        X    = 3'd1,
        Y    = 3'd2,
        NULL = 3'd3,
        EXEC = 3'd4,
        PC   = 3'd5,
        ISR  = 3'd6,
        OSR  = 3'd7
    } mov_operand_t;

    typedef struct packed {
        opcode_t      opcode;
        logic [4:0]   rsvd;
        jmp_cond_t    cond;
        pc_t          target;
    } instr_jmp_t;

    // MOV source sits in data[2:0]
    typedef struct packed {
        opcode_t      opcode;
        logic [4:0]   rsvd;
        mov_operand_t dest;
        logic [4:0]   data;
    } instr_opnd_t;

    typedef struct packed {
        opcode_t      opcode;
        logic [4:0]   rsvd;
        logic         pull;
        logic         if_empty;
        logic         block;
        logic [4:0]   rsvd_low;
    } instr_fifo_t;

    typedef union packed {
        instr_jmp_t  jmp;
        instr_opnd_t opnd;
        instr_fifo_t fifo;
    } instr_t;

    typedef struct packed {
        logic       full;
        logic       empty;
        logic [2:0] count;
    } fifo_status_t;

    typedef struct packed {
        logic   load;
        word_t  load_data;
        logic   shift_en;
        count_t shift_count;
    } osr_ctrl_t;

    typedef struct packed {
        logic       out_shiftdir;  // 1 shifts right
        logic [4:0] pull_thresh;   // 0 means 32
    } sm_config_t;

endpackage

`default_nettype wire
